/* vlog.f */
+incdir+design
design/tcdm_pkg.sv
design/wide_req_fifo.sv
design/shallow_router.sv
design/bank_reorder.sv
design/sram_bank.sv
design/tcdm_subsys_top.sv
test/tb_clk_gen.sv
test/tcdm_subsys_tb.sv

/* test/tcdm_subsys_tb.sv */
// tcdm_subsys_tb: stimulus, LFSR, reference memory model, assertions and reporting
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_subsys_tb;

  import tcdm_pkg::*;

  localparam int unsigned NW        = `TCDM_WIDE_WORDS;
  localparam int unsigned DW        = 32 * NW;
  localparam int unsigned BW        = 4 * NW;
  localparam int unsigned ADDR_W    = `TCDM_ADDR_W;
  localparam int unsigned IDX_W     = ADDR_W - 2;
  localparam int unsigned RW        = `TCDM_BANK_AW;
  localparam int unsigned IW        = `TCDM_BANK_IW;
  localparam int unsigned MEM_WORDS = 2 ** IDX_W;
  localparam int unsigned TIMEOUT   = 50;

  logic        clk;
  logic        rst_n;
  logic        clear;
  logic        req;
  wide_req_t   req_data;
  logic        gnt;
  logic        r_valid;
  wide_rsp_t   r_data;

  // reference memory by linear word index
  logic [31:0]   ref_mem [0:MEM_WORDS-1];
  // expected responses in acceptance order, top bit marks a checked read
  logic [DW:0]   exp_q [$];
  int unsigned   acc_cnt;
  int unsigned   rsp_cnt;
  int unsigned   errors;
  logic [31:0]   lfsr_q;

  tb_clk_gen clk_gen_i (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  tcdm_subsys_top dut_i (
    .clk_i      ( clk      ),
    .rst_ni     ( rst_n    ),
    .clear_i    ( clear    ),
    .req_i      ( req      ),
    .req_data_i ( req_data ),
    .gnt_o      ( gnt      ),
    .r_valid_o  ( r_valid  ),
    .r_data_o   ( r_data   )
  );

  // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [127:0] rnd(input int unsigned nbits);
    logic [127:0] val;
    logic         fb;
    val = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[126:0], fb};
    end
    return val;
  endfunction

  // preload value, every index bit shows up
  function automatic logic [31:0] fill_word(input int unsigned idx);
    logic [8:0] w;
    w = 9'(idx);
    return {w, ~w, w ^ 9'h1a5, 5'h0b};
  endfunction

  // random row, bank index in lo .. lo+span-1
  function automatic logic [ADDR_W-1:0] rand_addr(input int unsigned lo, input int unsigned span);
    logic [IW-1:0] bank;
    bank = IW'(lo + rnd(IW) % span);
    return {RW'(rnd(RW)), bank, 2'b00};
  endfunction

  task automatic count_timeout(input string msg);
    $display("%s at %0t ns", msg, $time);
    errors++;
  endtask

  task automatic report(input int unsigned num, input string name, input int unsigned err_start);
    $display("[test %0d] %s: %0d errors", num, name, errors - err_start);
  endtask

  // model update at acceptance, words follow the linear index and wrap with it
  task automatic model_accept(input wide_req_t r);
    logic [IDX_W-1:0] idx;
    logic [DW-1:0]    rd;
    for (int unsigned k = 0; k < NW; k++) begin
      idx = r.addr[ADDR_W-1:2] + IDX_W'(k);
      if (r.opc == TCDM_WRITE) begin
        for (int unsigned b = 0; b < 4; b++) begin
          if (r.be[k*4+b]) begin
            ref_mem[idx][b*8 +: 8] = r.data[k*32+b*8 +: 8];
          end
        end
      end
      rd[k*32 +: 32] = ref_mem[idx];
    end
    exp_q.push_back({r.opc == TCDM_READ, rd});
    acc_cnt++;
  endtask

  // holds the request until gnt_o, returns at the accepting edge
  task automatic send(input tcdm_opc_e opc, input logic [ADDR_W-1:0] addr,
                      input logic [DW-1:0] data, input logic [BW-1:0] be);
    wide_req_t   r;
    int unsigned n;
    r        = '{opc: opc, addr: addr, data: data, be: be};
    req      <= 1'b1;
    req_data <= r;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!gnt && n < TIMEOUT);
    if (!gnt) begin
      count_timeout("gnt_o stayed low, request never accepted");
    end else begin
      model_accept(r);
    end
  endtask

  // counters are stable at the falling edge
  task automatic drain();
    int unsigned n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (rsp_cnt != acc_cnt && n < TIMEOUT);
    if (rsp_cnt != acc_cnt) begin
      count_timeout("timed out waiting for outstanding responses");
    end
    @(posedge clk);
  endtask

  // single read into an idle pipeline, response expected two edges after acceptance
  task automatic read_latency(input logic [ADDR_W-1:0] addr);
    int unsigned n;
    send(TCDM_READ, addr, '0, '0);
    req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!r_valid && n < TIMEOUT);
    if (!r_valid) begin
      count_timeout("timed out waiting for the read response");
    end else begin
      assert (n == 2) else begin
        $display("mismatch at %0t ns: read latency %0d cycles, expected 2", $time, n);
        errors++;
      end
    end
  endtask

  // response checker, pops one expectation per strobe
  always @(posedge clk) begin : check_rsp
    logic [DW:0] expd;
    if (rst_n && r_valid && exp_q.size() > 0) begin
      expd = exp_q.pop_front();
      rsp_cnt++;
      if (expd[DW]) begin
        assert (r_data.data === expd[DW-1:0]) else begin
          $display("mismatch at %0t ns: read data %h, expected %h",
                   $time, r_data.data, expd[DW-1:0]);
          errors++;
        end
      end
    end
  end

  // a strobe needs an accepted request still waiting for it
  assert property (@(posedge clk) disable iff (!rst_n) r_valid |-> acc_cnt > rsp_cnt)
    else begin
      $display("response strobe at %0t ns with no request outstanding", $time);
      errors++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown({r_valid, gnt}))
    else begin
      $display("gnt_o or r_valid_o unknown at %0t ns", $time);
      errors++;
    end

  initial begin : watchdog
    #100us;
    $display("simulation time limit reached, run stopped");
    $display("test failed");
    $finish;
  end

  initial begin : stimulus
    logic [ADDR_W-1:0] addr;
    logic [DW-1:0]     data;
    int unsigned       n;
    int unsigned       err_start;
    lfsr_q   = 32'h5e60fe86;
    acc_cnt  = 0;
    rsp_cnt  = 0;
    errors   = 0;
    req      = 1'b0;
    clear    = 1'b0;
    req_data = '0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!rst_n && n < TIMEOUT);
    if (!rst_n) count_timeout("reset never released");

    // idle outputs before any request
    err_start = errors;
    repeat (4) begin
      @(posedge clk);
      assert (gnt && !r_valid) else begin
        $display("mismatch at %0t ns: gnt_o %b r_valid_o %b, expected 1 and 0",
                 $time, gnt, r_valid);
        errors++;
      end
    end
    report(1, "idle after reset", err_start);

    // preload whole memory back to back so later reads are defined
    for (int unsigned i = 0; i < MEM_WORDS / NW; i++) begin
      for (int unsigned k = 0; k < NW; k++) begin
        data[k*32 +: 32] = fill_word(i * NW + k);
      end
      send(TCDM_WRITE, ADDR_W'(i * NW * 4), data, '1);
    end
    req <= 1'b0;
    drain();

    err_start = errors;
    addr = rand_addr(0, 5);
    send(TCDM_WRITE, addr, rnd(DW), '1);
    req <= 1'b0;
    drain();
    read_latency(addr);
    drain();
    report(2, "write then read, latency", err_start);

    // start bank 5 to 7, upper words land in the next row
    err_start = errors;
    repeat (4) begin
      addr = rand_addr(5, 3);
      send(TCDM_WRITE, addr, rnd(DW), '1);
      send(TCDM_READ, addr, '0, '0);
      send(TCDM_READ, addr + ADDR_W'(4), '0, '0);
    end
    req <= 1'b0;
    drain();
    report(3, "wrapped accesses", err_start);

    err_start = errors;
    repeat (4) begin
      addr = rand_addr(0, 8);
      send(TCDM_WRITE, addr, rnd(DW), BW'(rnd(BW)));
      send(TCDM_READ, addr, '0, '0);
    end
    req <= 1'b0;
    drain();
    report(4, "partial writes", err_start);

    err_start = errors;
    for (int unsigned i = 0; i < 20; i++) begin
      addr = rand_addr(0, 8);
      if (rnd(1) != 0) begin
        send(TCDM_WRITE, addr, rnd(DW), BW'(rnd(BW)));
      end else begin
        send(TCDM_READ, addr, '0, '0);
      end
    end
    req <= 1'b0;
    drain();
    report(5, "back to back stream", err_start);

    // write sits at the FIFO head when clear hits, read arrives during clear
    err_start = errors;
    addr = rand_addr(0, 8);
    req      <= 1'b1;
    req_data <= '{opc: TCDM_WRITE, addr: addr, data: rnd(DW), be: '1};
    @(posedge clk);
    clear    <= 1'b1;
    req_data <= '{opc: TCDM_READ, addr: addr, data: '0, be: '0};
    @(posedge clk);
    clear <= 1'b0;
    req   <= 1'b0;
    repeat (4) @(posedge clk);
    // old contents expected, dropped write never reached the banks
    send(TCDM_READ, addr, '0, '0);
    send(TCDM_WRITE, addr, rnd(DW), '1);
    send(TCDM_READ, addr, '0, '0);
    req <= 1'b0;
    drain();
    report(6, "clear with pending requests", err_start);

    $display("responses checked: %0d of %0d accepted, errors: %0d", rsp_cnt, acc_cnt, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : tcdm_subsys_tb

/* test/tb_clk_gen.sv */
// tb_clk_gen: testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam time HALF_PERIOD = 20ns;

  // 40 ns free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // reset held low for three rising edges
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule : tb_clk_gen

/* design/tcdm_subsys_top.sv */
// tcdm_subsys_top: wide port with input FIFO, shallow router, bank reorder network and eight banks
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_subsys_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  // wide request port, req/gnt handshake
  input  logic                req_i,
  input  tcdm_pkg::wide_req_t req_data_i,
  output logic                gnt_o,
  // wide response strobe
  output logic                r_valid_o,
  output tcdm_pkg::wide_rsp_t r_data_o
);

  import tcdm_pkg::*;

  // FIFO head towards the router
  logic       fifo_full;
  logic       fifo_valid;
  logic       fifo_pop;
  wide_req_t  fifo_head;

  // router to reorder network
  word_req_t  word_req [0:`TCDM_WIDE_WORDS-1];
  word_rsp_t  word_rsp [0:`TCDM_WIDE_WORDS-1];
  logic [2:0] bank_offset;

  // reorder network to banks
  word_req_t  bank_req [0:`TCDM_NB_BANKS-1];
  word_rsp_t  bank_rsp [0:`TCDM_NB_BANKS-1];

  // only back-pressure is a full FIFO
  assign gnt_o = ~fifo_full;

  wide_req_fifo i_fifo (
    .clk_i   ( clk_i         ),
    .rst_ni  ( rst_ni        ),
    .clear_i ( clear_i       ),
    .push_i  ( req_i & gnt_o ),
    .data_i  ( req_data_i    ),
    .full_o  ( fifo_full     ),
    .valid_o ( fifo_valid    ),
    .pop_i   ( fifo_pop      ),
    .data_o  ( fifo_head     )
  );

  shallow_router i_router (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .fifo_valid_i  ( fifo_valid  ),
    .fifo_req_i    ( fifo_head   ),
    .pop_o         ( fifo_pop    ),
    .word_req_o    ( word_req    ),
    .bank_offset_o ( bank_offset ),
    .word_rsp_i    ( word_rsp    ),
    .r_valid_o     ( r_valid_o   ),
    .rsp_o         ( r_data_o    )
  );

  bank_reorder i_reorder (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .clear_i    ( clear_i     ),
    .order_i    ( bank_offset ),
    .word_req_i ( word_req    ),
    .word_rsp_o ( word_rsp    ),
    .bank_req_o ( bank_req    ),
    .bank_rsp_i ( bank_rsp    )
  );

  // word-interleaved bank array
  for (genvar b = 0; b < `TCDM_NB_BANKS; b++) begin : gen_banks
    sram_bank i_bank (
      .clk_i  ( clk_i       ),
      .rst_ni ( rst_ni      ),
      .req_i  ( bank_req[b] ),
      .rsp_o  ( bank_rsp[b] )
    );
  end

endmodule : tcdm_subsys_top

/* design/sram_bank.sv */
// sram_bank: 32-bit SRAM bank with byte enables and registered one-cycle response
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module sram_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::word_req_t req_i,
  output tcdm_pkg::word_rsp_t rsp_o
);

  import tcdm_pkg::*;

  localparam int unsigned NB_WORDS = 2 ** `TCDM_BANK_AW;

  // word storage
  logic [31:0] mem_q [0:NB_WORDS-1];

  logic        rvalid_q;
  logic [31:0] rdata_q;

  // write port, only the enabled bytes change
  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.opc == TCDM_WRITE) begin
      for (int unsigned b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem_q[req_i.addr][b*8 +: 8] <= req_i.data[b*8 +: 8];
        end
      end
    end
  end

  // read data captured on every access, old data on a write
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= mem_q[req_i.addr];
    end
  end

  // response valid one cycle after any request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.valid;
    end
  end

  assign rsp_o.valid = rvalid_q;
  assign rsp_o.data  = rdata_q;

endmodule : sram_bank

/* design/bank_reorder.sv */
// bank_reorder: rotation of word requests onto the banks and of bank responses back to word order
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module bank_reorder (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  // bank index of word 0
  input  logic [2:0]          order_i,
  // word side
  input  tcdm_pkg::word_req_t word_req_i [0:`TCDM_WIDE_WORDS-1],
  output tcdm_pkg::word_rsp_t word_rsp_o [0:`TCDM_WIDE_WORDS-1],
  // bank side
  output tcdm_pkg::word_req_t bank_req_o [0:`TCDM_NB_BANKS-1],
  input  tcdm_pkg::word_rsp_t bank_rsp_i [0:`TCDM_NB_BANKS-1]
);

  localparam int unsigned NB_WORDS = `TCDM_WIDE_WORDS;
  localparam int unsigned NB_BANKS = `TCDM_NB_BANKS;
  localparam int unsigned IW       = `TCDM_BANK_IW;

  // offset of the access now waiting for its bank responses
  logic [IW-1:0] order_q;

  // forward rotation
  always_comb begin
    // truncation to IW bits gives the mod NB_BANKS wrap
    logic [IW-1:0] bank_idx;
    // banks not targeted see an idle request
    for (int unsigned b = 0; b < NB_BANKS; b++) begin
      bank_req_o[b] = '0;
    end
    for (int unsigned k = 0; k < NB_WORDS; k++) begin
      bank_idx = order_i + IW'(k);
      bank_req_o[bank_idx] = word_req_i[k];
    end
  end

  // hold the issue offset for the response cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      order_q <= '0;
    end else if (clear_i) begin
      order_q <= '0;
    end else begin
      order_q <= order_i;
    end
  end

  // backward rotation with the registered offset
  // next request may already be on order_i here
  always_comb begin
    logic [IW-1:0] bank_idx;
    for (int unsigned k = 0; k < NB_WORDS; k++) begin
      bank_idx = order_q + IW'(k);
      word_rsp_o[k] = bank_rsp_i[bank_idx];
    end
  end

endmodule : bank_reorder

/* design/shallow_router.sv */
// shallow_router: wide request split into word requests with wrapped row addresses, response merge
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module shallow_router (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  // FIFO head
  input  logic                fifo_valid_i,
  input  tcdm_pkg::wide_req_t fifo_req_i,
  output logic                pop_o,
  // word requests towards the reorder network
  output tcdm_pkg::word_req_t word_req_o [0:`TCDM_WIDE_WORDS-1],
  output logic [2:0]          bank_offset_o,
  // word responses, already back in word order
  input  tcdm_pkg::word_rsp_t word_rsp_i [0:`TCDM_WIDE_WORDS-1],
  // wide response strobe
  output logic                r_valid_o,
  output tcdm_pkg::wide_rsp_t rsp_o
);

  localparam int unsigned NB_WORDS = `TCDM_WIDE_WORDS;
  localparam int unsigned NB_BANKS = `TCDM_NB_BANKS;
  localparam int unsigned IW       = `TCDM_BANK_IW;
  localparam int unsigned AW       = `TCDM_BANK_AW;

  // address fields of the head request
  logic [IW-1:0]  bank_offset;
  logic [AW-1:0]  row_addr;

  // request leaves the FIFO this cycle
  logic           issue;
  // issue strobe delayed to line up with the bank responses
  logic           issue_q;

  // bank index bits sit right above the byte offset
  assign bank_offset = fifo_req_i.addr[IW+1:2];
  // row address is everything above the bank index
  assign row_addr    = fifo_req_i.addr[`TCDM_ADDR_W-1:IW+2];

  assign bank_offset_o = bank_offset;

  // banks never stall, so a valid head is issued at once
  // a clear drops the head before it reaches the banks
  assign issue = fifo_valid_i & ~clear_i;
  assign pop_o = issue;

  // per-word split
  always_comb begin
    // offset plus word index, one extra bit for the wrap carry
    logic [IW:0] bank_sum;
    for (int unsigned k = 0; k < NB_WORDS; k++) begin
      bank_sum = {1'b0, bank_offset} + (IW + 1)'(k);
      word_req_o[k].valid = issue;
      word_req_o[k].opc   = fifo_req_i.opc;
      word_req_o[k].data  = fifo_req_i.data[k*32 +: 32];
      word_req_o[k].be    = fifo_req_i.be[k*4 +: 4];
      // words that wrap past the last bank land in the next row
      if (bank_sum >= (IW + 1)'(NB_BANKS)) begin
        word_req_o[k].addr = row_addr + 1'b1;
      end else begin
        word_req_o[k].addr = row_addr;
      end
    end
  end

  // issue strobe register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_q <= 1'b0;
    end else if (clear_i) begin
      issue_q <= 1'b0;
    end else begin
      issue_q <= issue;
    end
  end

  // response strobe, word 0 stands for the whole group
  assign r_valid_o = issue_q & word_rsp_i[0].valid;

  // merge word data back into the wide word
  always_comb begin
    for (int unsigned k = 0; k < NB_WORDS; k++) begin
      rsp_o.data[k*32 +: 32] = word_rsp_i[k].data;
    end
  end

endmodule : shallow_router

/* design/wide_req_fifo.sv */
// wide_req_fifo: circular input FIFO for wide requests with full flag and synchronous clear
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module wide_req_fifo (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  // write side
  input  logic                push_i,
  input  tcdm_pkg::wide_req_t data_i,
  output logic                full_o,
  // read side
  output logic                valid_o,
  input  logic                pop_i,
  output tcdm_pkg::wide_req_t data_o
);

  import tcdm_pkg::*;

  localparam int unsigned DEPTH = `TCDM_FIFO_DEPTH;
  // pointer width, kept at one bit for a single-entry FIFO
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // storage, payload only
  wide_req_t            mem_q [0:DEPTH-1];

  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;

  logic                 do_push;
  logic                 do_pop;

  // status flags straight from the occupancy count
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);

  // qualified handshakes
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & valid_o;

  // head entry is always presented
  assign data_o = mem_q[rd_ptr_q];

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        // wrap explicitly, depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // count moves only when one side acts alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // write port, entry readable from the next cycle
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : wide_req_fifo

/* design/tcdm_pkg.sv */
// package with the opcode enum and the wide and per-word request and response structs
`include "tcdm_cfg.svh"

package tcdm_pkg;

  // request opcode
  typedef enum logic {
    TCDM_READ  = 1'b0,
    TCDM_WRITE = 1'b1
  } tcdm_opc_e;

  // wide request as seen at the initiator port
  typedef struct packed {
    tcdm_opc_e                           opc;
    logic [`TCDM_ADDR_W-1:0]             addr;
    logic [32*`TCDM_WIDE_WORDS-1:0]      data;
    logic [4*`TCDM_WIDE_WORDS-1:0]       be;
  } wide_req_t;

  // wide response, read data only
  typedef struct packed {
    logic [32*`TCDM_WIDE_WORDS-1:0]      data;
  } wide_rsp_t;

  // one 32-bit word request towards a bank
  typedef struct packed {
    logic                                valid;
    tcdm_opc_e                           opc;
    // word address inside the bank
    logic [`TCDM_BANK_AW-1:0]            addr;
    logic [31:0]                         data;
    logic [3:0]                          be;
  } word_req_t;

  // one 32-bit word response from a bank
  typedef struct packed {
    logic                                valid;
    logic [31:0]                         data;
  } word_rsp_t;

endpackage : tcdm_pkg

/* design/tcdm_cfg.svh */
// configuration macros for bank count, wide-word count, bank address width and FIFO depth
`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

// number of word-interleaved banks, power of two
`define TCDM_NB_BANKS 8

// 32-bit words carried by one wide access, at most the bank count
`define TCDM_WIDE_WORDS 4

// word address bits inside one bank (64 words)
`define TCDM_BANK_AW 6

// entries in the wide request FIFO
`define TCDM_FIFO_DEPTH 4

// derived widths
// bank index bits taken from the byte address
`define TCDM_BANK_IW ($clog2(`TCDM_NB_BANKS))
// full byte address: row bits, bank index bits, two byte bits
`define TCDM_ADDR_W (`TCDM_BANK_AW + `TCDM_BANK_IW + 2)

`endif
